//--- src/axi_mem_pkg.sv
// shared AXI4 channel types and codes for the SRAM slave
// data width is fixed at 64 bits, so every beat carries 8 strobe bits
package axi_mem_pkg;

   // bus geometry
   localparam int data_w = 64;
   localparam int strb_w = data_w / 8;

   // memory window starts here, depth is set per instance
   localparam logic [31:0] mem_base = 32'h8000_0000;

   // AXI4 burst encodings
   localparam logic [1:0] burst_fixed = 2'b00;
   localparam logic [1:0] burst_incr  = 2'b01;
   localparam logic [1:0] burst_wrap  = 2'b10;

   // AXI4 response encodings, only two are ever returned
   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   // address channel request, shared by AR and AW
   typedef struct packed {
      logic [31:0] addr;
      logic [7:0]  len;     // beats minus one
      logic [2:0]  size;    // log2 of bytes per beat
      logic [1:0]  burst;
   } axi_req_t;

   // write data beat
   typedef struct packed {
      logic [data_w-1:0] data;
      logic [strb_w-1:0] strb;
      logic              last;  // carried but not checked
   } axi_w_t;

   // read data beat
   typedef struct packed {
      logic [data_w-1:0] data;
      logic [1:0]        resp;
      logic              last;
   } axi_r_t;

   // write response
   typedef struct packed {
      logic [1:0] resp;
   } axi_b_t;

endpackage

//--- src/axi_burst_addr.sv
`timescale 1ns/1ps
// per-beat address walker; WRAP expects len of 1, 3, 7 or 15 as AXI4 requires
// index is only meaningful while ok is high
module axi_burst_addr #(
   parameter int mem_words = 4096
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         start,
   input  axi_mem_pkg::axi_req_t        req,
   input  logic                         advance,
   output logic [$clog2(mem_words)-1:0] index,
   output logic                         ok,
   output logic                         last
);
   localparam int idx_w = $clog2(mem_words);
   localparam logic [31:0] mem_bytes = 32'(mem_words) * 32'd8;

   logic [31:0] addr;       // byte address of current beat
   logic [7:0]  remain;     // beats left after this one
   logic [2:0]  size;
   logic [1:0]  burst;
   logic [31:0] wrap_mask;  // wrap block size minus one
   logic [31:0] step;
   logic [31:0] offset;
   logic [31:0] next_addr;

   assign step   = 32'd1 << size;
   assign offset = addr - axi_mem_pkg::mem_base;

   always_comb begin
      case (burst)
         axi_mem_pkg::burst_fixed: next_addr = addr;
         axi_mem_pkg::burst_wrap:  next_addr = (addr & ~wrap_mask) | ((addr + step) & wrap_mask);
         default:                  next_addr = (addr & ~(step - 32'd1)) + step;  // INCR, aligned
      endcase
   end

   always_ff @(posedge clk) begin
      if (start) begin
         addr      <= req.addr;
         size      <= req.size;
         burst     <= req.burst;
         wrap_mask <= ((32'(req.len) + 32'd1) << req.size) - 32'd1;
      end else if (advance) begin
         addr <= next_addr;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         remain <= '0;
      end else if (start) begin
         remain <= req.len;
      end else if (advance) begin
         remain <= remain - 8'd1;
      end
   end

   assign index = offset[3 +: idx_w];  // 64-bit word granularity
   assign ok    = (addr >= axi_mem_pkg::mem_base) && (offset < mem_bytes) && (size <= 3'd3);
   assign last  = (remain == 8'd0);

endmodule

//--- src/sram_bank.sv
`timescale 1ns/1ps
// 64-bit word SRAM, one registered read port and one byte-masked write port
// contents start undefined
module sram_bank #(
   parameter int mem_words = 4096
) (
   input  logic                              clk,
   input  logic                              rd_en,
   input  logic [$clog2(mem_words)-1:0]      rd_index,
   output logic [axi_mem_pkg::data_w-1:0]    rd_data,
   input  logic                              wr_en,
   input  logic [$clog2(mem_words)-1:0]      wr_index,
   input  logic [axi_mem_pkg::data_w-1:0]    wr_data,
   input  logic [axi_mem_pkg::strb_w-1:0]    wr_strb
);
   logic [axi_mem_pkg::data_w-1:0] mem [0:mem_words-1];

   // output holds while rd_en is low
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_index];
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int i = 0; i < axi_mem_pkg::strb_w; i++) begin
            if (wr_strb[i]) begin
               mem[wr_index][8*i +: 8] <= wr_data[8*i +: 8];
            end
         end
      end
   end

endmodule

//--- src/axi_read_engine.sv
`timescale 1ns/1ps
// AR/R engine, one burst at a time; first beat two cycles after the AR handshake
// reads always return the whole word whatever the beat size
module axi_read_engine #(
   parameter int mem_words = 4096
) (
   input  logic                              clk,
   input  logic                              rst,
   input  axi_mem_pkg::axi_req_t             ar,
   input  logic                              ar_valid,
   output logic                              ar_ready,
   output axi_mem_pkg::axi_r_t               r,
   output logic                              r_valid,
   input  logic                              r_ready,
   output logic                              start,
   output axi_mem_pkg::axi_req_t             req,
   output logic                              advance,
   input  logic [$clog2(mem_words)-1:0]      index,
   input  logic                              ok,
   input  logic                              last,
   output logic                              rd_en,
   output logic [$clog2(mem_words)-1:0]      rd_index,
   input  logic [axi_mem_pkg::data_w-1:0]    rd_data
);
   typedef enum logic [1:0] {
      st_idle,
      st_fetch,   // generator loads
      st_stream
   } state_t;

   state_t state;
   logic   issue_done;  // last beat already sent to the bank
   logic   ok_q;
   logic   last_q;

   assign ar_ready = (state == st_idle);
   assign start    = (state == st_fetch);

   // read only into an empty slot or one being drained this cycle
   assign rd_en    = (state == st_stream) && !issue_done && (!r_valid || r_ready);
   assign advance  = rd_en;
   assign rd_index = index;

   assign r = '{data: rd_data,
                resp: ok_q ? axi_mem_pkg::resp_okay : axi_mem_pkg::resp_slverr,
                last: last_q};

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= st_idle;
         issue_done <= 1'b0;
         r_valid    <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               issue_done <= 1'b0;
               if (ar_valid) begin
                  state <= st_fetch;
               end
            end
            st_fetch: state <= st_stream;
            default: begin
               if (r_valid && r_ready && r.last) begin
                  state <= st_idle;
               end
            end
         endcase
         if (rd_en && last) begin
            issue_done <= 1'b1;
         end
         if (rd_en) begin
            r_valid <= 1'b1;
         end else if (r_ready) begin
            r_valid <= 1'b0;
         end
      end
   end

   // beat flags travel with the word in flight
   always_ff @(posedge clk) begin
      if (ar_valid && ar_ready) begin
         req <= ar;
      end
      if (rd_en) begin
         ok_q   <= ok;
         last_q <= last;
      end
   end

endmodule

//--- src/axi_write_engine.sv
`timescale 1ns/1ps
// AW/W/B engine; the burst ends on its own beat count, wlast is ignored
// out-of-range beats are accepted but never reach the bank
module axi_write_engine #(
   parameter int mem_words = 4096
) (
   input  logic                              clk,
   input  logic                              rst,
   input  axi_mem_pkg::axi_req_t             aw,
   input  logic                              aw_valid,
   output logic                              aw_ready,
   input  axi_mem_pkg::axi_w_t               w,
   input  logic                              w_valid,
   output logic                              w_ready,
   output axi_mem_pkg::axi_b_t               b,
   output logic                              b_valid,
   input  logic                              b_ready,
   output logic                              start,
   output axi_mem_pkg::axi_req_t             req,
   output logic                              advance,
   input  logic [$clog2(mem_words)-1:0]      index,
   input  logic                              ok,
   input  logic                              last,
   output logic                              wr_en,
   output logic [$clog2(mem_words)-1:0]      wr_index,
   output logic [axi_mem_pkg::data_w-1:0]    wr_data,
   output logic [axi_mem_pkg::strb_w-1:0]    wr_strb
);
   typedef enum logic [1:0] {
      st_idle,
      st_data,
      st_respond
   } state_t;

   state_t state;
   logic   err;   // sticky over the burst
   logic   beat;

   assign aw_ready = (state == st_idle);
   assign start    = aw_valid && aw_ready;  // generator loads on the AW edge
   assign req      = aw;

   assign w_ready  = (state == st_data);
   assign beat     = w_valid && w_ready;
   assign advance  = beat;

   assign wr_en    = beat && ok;
   assign wr_index = index;
   assign wr_data  = w.data;
   assign wr_strb  = w.strb;

   assign b_valid  = (state == st_respond);
   assign b        = '{resp: err ? axi_mem_pkg::resp_slverr : axi_mem_pkg::resp_okay};

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
         err   <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (start) begin
                  state <= st_data;
                  err   <= 1'b0;
               end
            end
            st_data: begin
               if (beat) begin
                  if (!ok) begin
                     err <= 1'b1;
                  end
                  if (last) begin
                     state <= st_respond;
                  end
               end
            end
            default: begin
               if (b_ready) begin
                  state <= st_idle;
               end
            end
         endcase
      end
   end

endmodule

//--- src/axi_sram.sv
`timescale 1ns/1ps
// AXI4 burst slave over on-chip SRAM at mem_base, mem_words 64-bit words deep
// read and write paths are independent, same-address hazards are not ordered
module axi_sram #(
   parameter int mem_words = 4096
) (
   input  logic                  clk,
   input  logic                  rst,
   input  axi_mem_pkg::axi_req_t ar,
   input  logic                  ar_valid,
   output logic                  ar_ready,
   output axi_mem_pkg::axi_r_t   r,
   output logic                  r_valid,
   input  logic                  r_ready,
   input  axi_mem_pkg::axi_req_t aw,
   input  logic                  aw_valid,
   output logic                  aw_ready,
   input  axi_mem_pkg::axi_w_t   w,
   input  logic                  w_valid,
   output logic                  w_ready,
   output axi_mem_pkg::axi_b_t   b,
   output logic                  b_valid,
   input  logic                  b_ready
);
   localparam int idx_w = $clog2(mem_words);

   // read side
   logic                           rd_start;
   logic                           rd_advance;
   logic                           rd_ok;
   logic                           rd_last;
   axi_mem_pkg::axi_req_t          rd_req;
   logic [idx_w-1:0]               rd_gen_index;
   logic                           rd_en;
   logic [idx_w-1:0]               rd_index;
   logic [axi_mem_pkg::data_w-1:0] rd_data;

   // write side
   logic                           wr_start;
   logic                           wr_advance;
   logic                           wr_ok;
   logic                           wr_last;
   axi_mem_pkg::axi_req_t          wr_req;
   logic [idx_w-1:0]               wr_gen_index;
   logic                           wr_en;
   logic [idx_w-1:0]               wr_index;
   logic [axi_mem_pkg::data_w-1:0] wr_data;
   logic [axi_mem_pkg::strb_w-1:0] wr_strb;

   axi_read_engine #(.mem_words(mem_words)) rd_engine (
      .clk(clk), .rst(rst),
      .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
      .r(r), .r_valid(r_valid), .r_ready(r_ready),
      .start(rd_start), .req(rd_req), .advance(rd_advance),
      .index(rd_gen_index), .ok(rd_ok), .last(rd_last),
      .rd_en(rd_en), .rd_index(rd_index), .rd_data(rd_data)
   );

   axi_write_engine #(.mem_words(mem_words)) wr_engine (
      .clk(clk), .rst(rst),
      .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
      .w(w), .w_valid(w_valid), .w_ready(w_ready),
      .b(b), .b_valid(b_valid), .b_ready(b_ready),
      .start(wr_start), .req(wr_req), .advance(wr_advance),
      .index(wr_gen_index), .ok(wr_ok), .last(wr_last),
      .wr_en(wr_en), .wr_index(wr_index), .wr_data(wr_data), .wr_strb(wr_strb)
   );

   axi_burst_addr #(.mem_words(mem_words)) rd_addr_gen (
      .clk(clk), .rst(rst),
      .start(rd_start), .req(rd_req), .advance(rd_advance),
      .index(rd_gen_index), .ok(rd_ok), .last(rd_last)
   );

   axi_burst_addr #(.mem_words(mem_words)) wr_addr_gen (
      .clk(clk), .rst(rst),
      .start(wr_start), .req(wr_req), .advance(wr_advance),
      .index(wr_gen_index), .ok(wr_ok), .last(wr_last)
   );

   sram_bank #(.mem_words(mem_words)) bank (
      .clk(clk),
      .rd_en(rd_en), .rd_index(rd_index), .rd_data(rd_data),
      .wr_en(wr_en), .wr_index(wr_index), .wr_data(wr_data), .wr_strb(wr_strb)
   );

endmodule

//--- bench/axi_sram_tb.sv
`timescale 1ns/1ps
// AXI4 master testbench for axi_sram with mem_words 1024, so the window ends at 0x8000_2000
// bytes never written are unknown to the shadow model and are not compared
module axi_sram_tb;
   localparam int mem_words = 1024;
   localparam int max_cycles = 4000;  // well above the cycles all bursts take
   localparam logic [31:0] base = axi_mem_pkg::mem_base;

   logic                  clk = 1'b0;
   logic                  rst = 1'b1;
   axi_mem_pkg::axi_req_t ar = '0;
   logic                  ar_valid = 1'b0;
   logic                  ar_ready;
   axi_mem_pkg::axi_r_t   r;
   logic                  r_valid;
   logic                  r_ready = 1'b0;
   axi_mem_pkg::axi_req_t aw = '0;
   logic                  aw_valid = 1'b0;
   logic                  aw_ready;
   axi_mem_pkg::axi_w_t   w = '0;
   logic                  w_valid = 1'b0;
   logic                  w_ready;
   axi_mem_pkg::axi_b_t   b;
   logic                  b_valid;
   logic                  b_ready = 1'b0;

   logic [63:0] shadow [int];  // expected word contents
   logic [63:0] known [int];   // bit mask of bytes written so far
   int          seed = 61;
   int          cycles = 0;

   axi_sram #(.mem_words(mem_words)) uut (
      .clk(clk), .rst(rst),
      .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
      .r(r), .r_valid(r_valid), .r_ready(r_ready),
      .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
      .w(w), .w_valid(w_valid), .w_ready(w_ready),
      .b(b), .b_valid(b_valid), .b_ready(b_ready)
   );

   initial begin
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles) begin
         $display("timeout: the test did not finish within %0d cycles", max_cycles);
         $display("Regression failed");
         $fatal(1, "timeout");
      end
   end

   task automatic abort_run(input string msg);
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      $display("Regression failed");
      $fatal(1, "stopped at first error");
   endtask

   // a stalled channel must hold its payload
   assert property (@(posedge clk) disable iff (rst)
      (r_valid && !r_ready) |=> (r_valid && $stable(r)))
      else abort_run("r changed while r_ready was low");
   assert property (@(posedge clk) disable iff (rst)
      (b_valid && !b_ready) |=> (b_valid && $stable(b)))
      else abort_run("b changed while b_ready was low");

   // AXI4 beat address from the burst rules
   function automatic logic [31:0] beat_addr(input logic [31:0] start, input logic [7:0] len,
                                             input logic [2:0] size, input logic [1:0] burst,
                                             input int i);
      logic [31:0] bytes;
      logic [31:0] block;
      logic [31:0] low;
      bytes = 32'd1 << size;
      block = bytes * (32'(len) + 32'd1);
      low   = start - start % block;
      if (burst == axi_mem_pkg::burst_fixed) return start;
      if (burst == axi_mem_pkg::burst_wrap) return low + (start - low + bytes * 32'(i)) % block;
      return (i == 0) ? start : start - start % bytes + bytes * 32'(i);
   endfunction

   function automatic logic in_range(input logic [31:0] a, input logic [2:0] size);
      return (a >= base) && (a < base + 32'(mem_words * 8)) && (size <= 3'd3);
   endfunction

   function automatic void shadow_store(input logic [31:0] a, input logic [63:0] data,
                                        input logic [7:0] strb);
      int          idx;
      logic [63:0] word;
      logic [63:0] mask;
      idx  = int'((a - base) >> 3);
      word = shadow.exists(idx) ? shadow[idx] : 64'd0;
      mask = known.exists(idx) ? known[idx] : 64'd0;
      for (int k = 0; k < 8; k++) begin
         if (strb[k]) begin
            word[8*k +: 8] = data[8*k +: 8];
            mask[8*k +: 8] = 8'hff;
         end
      end
      shadow[idx] = word;
      known[idx]  = mask;
   endfunction

   function automatic logic word_matches(input logic [31:0] a, input logic [63:0] data);
      int idx;
      idx = int'((a - base) >> 3);
      if (!known.exists(idx)) return 1'b1;
      return ((data ^ shadow[idx]) & known[idx]) == 64'd0;
   endfunction

   task automatic write_burst(input logic [31:0] addr, input logic [7:0] len,
                              input logic [2:0] size, input logic [1:0] burst,
                              input logic rand_strb);
      logic [31:0] a;
      logic        err;
      int          i;
      err = 1'b0;
      @(negedge clk);
      aw       = '{addr: addr, len: len, size: size, burst: burst};
      aw_valid = 1'b1;
      while (!aw_ready) @(negedge clk);
      @(posedge clk);
      @(negedge clk);
      aw_valid = 1'b0;
      assert (!aw_ready && w_ready) else abort_run("w_ready not high the cycle after AW");
      for (i = 0; i <= int'(len); i++) begin
         w.data  = {$random(seed), $random(seed)};
         w.strb  = rand_strb ? 8'($random(seed)) : 8'hff;
         w.last  = (i == int'(len));
         w_valid = 1'b1;
         while (!w_ready) @(negedge clk);
         a = beat_addr(addr, len, size, burst, i);
         if (in_range(a, size)) shadow_store(a, w.data, w.strb);
         else err = 1'b1;
         @(posedge clk);
         @(negedge clk);
      end
      w_valid = 1'b0;
      assert (b_valid) else abort_run("b_valid not one cycle after the last W beat");
      @(negedge clk);  // b_ready low one cycle
      assert (b.resp == (err ? axi_mem_pkg::resp_slverr : axi_mem_pkg::resp_okay))
         else abort_run("wrong B response");
      b_ready = 1'b1;
      @(posedge clk);
      @(negedge clk);
      b_ready = 1'b0;
      assert (!b_valid && !w_ready && aw_ready) else abort_run("write engine not idle after B");
   endtask

   task automatic read_burst(input logic [31:0] addr, input logic [7:0] len,
                             input logic [2:0] size, input logic [1:0] burst,
                             input logic stall);
      logic [31:0] a;
      logic        exp_ok;
      int          i;
      @(negedge clk);
      ar       = '{addr: addr, len: len, size: size, burst: burst};
      ar_valid = 1'b1;
      while (!ar_ready) @(negedge clk);
      @(posedge clk);
      @(negedge clk);
      ar_valid = 1'b0;
      assert (!ar_ready && !r_valid) else abort_run("ar_ready or r_valid high after AR");
      @(negedge clk);
      assert (!r_valid) else abort_run("r_valid one cycle after AR");
      @(negedge clk);
      assert (r_valid) else abort_run("first r_valid not two cycles after AR");
      i = 0;
      while (i <= int'(len)) begin
         r_ready = stall ? 1'($random(seed)) : 1'b1;
         if (r_valid && r_ready) begin
            a      = beat_addr(addr, len, size, burst, i);
            exp_ok = in_range(a, size);
            assert (r.resp == (exp_ok ? axi_mem_pkg::resp_okay : axi_mem_pkg::resp_slverr))
               else abort_run("wrong read response");
            assert (r.last == (i == int'(len))) else abort_run("wrong rlast");
            assert (!exp_ok || word_matches(a, r.data)) else abort_run("read data mismatch");
            i++;
         end
         @(negedge clk);
      end
      r_ready = 1'b0;
      assert (ar_ready && !r_valid) else abort_run("read engine not idle after last beat");
   endtask

   initial begin
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      assert (!r_valid && !b_valid && ar_ready && aw_ready) else abort_run("bad reset state");
      // INCR, full words first so strobed bytes land on known data
      write_burst(base, 8'd15, 3'd3, axi_mem_pkg::burst_incr, 1'b0);
      write_burst(base, 8'd15, 3'd3, axi_mem_pkg::burst_incr, 1'b1);
      read_burst(base, 8'd15, 3'd3, axi_mem_pkg::burst_incr, 1'b0);
      // WRAP within the 32-byte block at 0x100
      write_burst(base + 32'h110, 8'd3, 3'd3, axi_mem_pkg::burst_wrap, 1'b0);
      read_burst(base + 32'h108, 8'd3, 3'd3, axi_mem_pkg::burst_wrap, 1'b0);
      // FIXED at one address
      write_burst(base + 32'h200, 8'd3, 3'd3, axi_mem_pkg::burst_fixed, 1'b1);
      read_burst(base + 32'h200, 8'd3, 3'd3, axi_mem_pkg::burst_fixed, 1'b0);
      // crossing the memory end, then the low words that out-of-range beats alias to
      write_burst(base + 32'h1ff0, 8'd3, 3'd3, axi_mem_pkg::burst_incr, 1'b0);
      read_burst(base + 32'h1ff0, 8'd3, 3'd3, axi_mem_pkg::burst_incr, 1'b0);
      read_burst(base, 8'd1, 3'd3, axi_mem_pkg::burst_incr, 1'b0);
      read_burst(base + 32'h100, 8'd1, 3'd4, axi_mem_pkg::burst_incr, 1'b0);
      // long read with random r_ready gaps
      write_burst(base + 32'h400, 8'd31, 3'd3, axi_mem_pkg::burst_incr, 1'b1);
      read_burst(base + 32'h400, 8'd31, 3'd3, axi_mem_pkg::burst_incr, 1'b1);
      $display("Regression passed");
      $finish;
   end

endmodule

//--- vlog.f
src/axi_mem_pkg.sv
src/axi_burst_addr.sv
src/sram_bank.sv
src/axi_read_engine.sv
src/axi_write_engine.sv
src/axi_sram.sv
bench/axi_sram_tb.sv

//--- run.sh
#!/bin/sh
# builds and runs the AXI SRAM testbench with Verilator
# the exit status is nonzero when the build fails or the simulation stops on $fatal
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module axi_sram_tb \
   --Mdir obj_dir -o axi_sram_sim &&
./obj_dir/axi_sram_sim ||
{ echo "simulation build or run failed"; exit 1; }
